// ==== rtl/plru_pkg.sv ====
//------------------------------
// Shared constants and types for the
// uTLB tree pseudo-LRU picker
// Entry, index and tree vectors
// Per-port read update struct
//------------------------------

package plru_pkg;

  //------------------------------
  // Sizes
  //------------------------------
  localparam int PLRU_ENTRY_NUM = 16;
  localparam int PLRU_IDX_W     = 4;
  // One node per internal vertex of the binary tree
  localparam int PLRU_NODE_NUM  = PLRU_ENTRY_NUM - 1;
  localparam int PLRU_HIT_PORTS = 2;

  //------------------------------
  // Vector types
  //------------------------------
  // Valid bits, hit one-hots and refill one-hot
  typedef logic [PLRU_ENTRY_NUM-1:0] entry_vec_t;

  // Binary entry number
  typedef logic [PLRU_IDX_W-1:0]     entry_idx_t;

  // Node bits in heap order
  //   bit 0        root
  //   bits 1..2    level 1, left to right
  //   bits 3..6    level 2
  //   bits 7..14   level 3, each picks one of two entries
  // Children of node n sit at 2n+1 and 2n+2
  typedef logic [PLRU_NODE_NUM-1:0]  tree_vec_t;

  //------------------------------
  // Read update from one hit port
  //------------------------------
  typedef struct packed {
    // New hit on this port this cycle
    logic       updt;
    // Entry that was hit
    entry_idx_t idx;
  } port_updt_t;

endpackage

// ==== rtl/plru_hit_track.sv ====
//------------------------------
// Hit port tracker
// One-hot to index decode per port
// Last-hit filter for repeated hits
//------------------------------

`timescale 1ns/1ps

module plru_hit_track (
  input  logic                                               lru_clk,
  input  logic                                               cpurst_b,
  input  plru_pkg::entry_vec_t                               hit_onehot0,
  input  plru_pkg::entry_vec_t                               hit_onehot1,
  input  logic                                               hit_vld0,
  input  logic                                               hit_vld1,
  output plru_pkg::port_updt_t [plru_pkg::PLRU_HIT_PORTS-1:0] rd_updt
);

  import plru_pkg::*;

  entry_vec_t                hit_onehot [PLRU_HIT_PORTS];
  logic [PLRU_HIT_PORTS-1:0] hit_vld;
  entry_idx_t                hit_idx    [PLRU_HIT_PORTS];
  entry_idx_t                last_idx   [PLRU_HIT_PORTS];

  // Anything that is not exactly one-hot maps to entry 0
  function automatic entry_idx_t onehot_to_idx(entry_vec_t vec);
    entry_idx_t idx;
    idx = '0;
    if ((vec != '0) && ((vec & (vec - 1'b1)) == '0))
    begin
      for (int i = 0; i < PLRU_ENTRY_NUM; i++)
      begin
        if (vec[i])
          idx = entry_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // Gather ports so both share one path
  assign hit_onehot[0] = hit_onehot0;
  assign hit_onehot[1] = hit_onehot1;
  assign hit_vld       = {hit_vld1, hit_vld0};

  //------------------------------
  // Decode and compare
  //------------------------------
  always_comb
  begin
    for (int p = 0; p < PLRU_HIT_PORTS; p++)
    begin
      hit_idx[p]      = onehot_to_idx(hit_onehot[p]);
      // Same entry as last time, tree already points away from it
      rd_updt[p].updt = hit_vld[p] && (hit_idx[p] != last_idx[p]);
      rd_updt[p].idx  = hit_idx[p];
    end
  end

  //------------------------------
  // Last hit per port
  //------------------------------
  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      for (int p = 0; p < PLRU_HIT_PORTS; p++)
        last_idx[p] <= '0;
    end
    else
    begin
      for (int p = 0; p < PLRU_HIT_PORTS; p++)
      begin
        if (hit_vld[p])
          last_idx[p] <= hit_idx[p];
      end
    end
  end

endmodule

// ==== rtl/plru_node.sv ====
//------------------------------
// Single PLRU tree node
// Refill write and two-port hit update
//------------------------------

`timescale 1ns/1ps

module plru_node #(
  parameter int LEVEL = 0,
  parameter int POS   = 0
) (
  input  logic                                               lru_clk,
  input  logic                                               cpurst_b,
  input  logic                                               refill_vld,
  input  plru_pkg::entry_idx_t                               refill_idx,
  input  plru_pkg::port_updt_t [plru_pkg::PLRU_HIT_PORTS-1:0] rd_updt,
  output logic                                               node_bit
);

  import plru_pkg::*;

  // Index bit that selects a child below this node
  localparam int SEL_BIT = PLRU_IDX_W - 1 - LEVEL;

  logic                      wr_hit;
  logic                      wr_val;
  logic [PLRU_HIT_PORTS-1:0] rd_hit;
  logic [PLRU_HIT_PORTS-1:0] rd_val;
  logic                      rd_load;
  logic                      rd_new;

  // Upper LEVEL bits of the index name the subtree, root covers all
  function automatic logic covers(entry_idx_t idx);
    return (idx >> (SEL_BIT + 1)) == entry_idx_t'(POS);
  endfunction

  //------------------------------
  // Refill path
  //------------------------------
  assign wr_hit = refill_vld && covers(refill_idx);
  // Point at the other half from the one just used
  assign wr_val = !refill_idx[SEL_BIT];

  //------------------------------
  // Hit paths
  //------------------------------
  always_comb
  begin
    for (int p = 0; p < PLRU_HIT_PORTS; p++)
    begin
      rd_hit[p] = rd_updt[p].updt && covers(rd_updt[p].idx);
      rd_val[p] = !rd_updt[p].idx[SEL_BIT];
    end
  end

  // Single port loads, two ports load only when they agree
  assign rd_load = (rd_hit == 2'b01) || (rd_hit == 2'b10)
                || ((rd_hit == 2'b11) && (rd_val[0] == rd_val[1]));
  assign rd_new  = rd_hit[0] ? rd_val[0] : rd_val[1];

  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      node_bit <= 1'b0;
    else if (wr_hit)
      node_bit <= wr_val;
    else if (rd_load)
      node_bit <= rd_new;
  end

endmodule

// ==== rtl/plru_victim_sel.sv ====
//------------------------------
// Victim selection
// Invalid-first scan, tree walk
// Refill index register, one-hot out
//------------------------------

`timescale 1ns/1ps

module plru_victim_sel (
  input  logic                 lru_clk,
  input  logic                 cpurst_b,
  input  plru_pkg::entry_vec_t entry_vld,
  input  plru_pkg::tree_vec_t  node_bits,
  input  logic                 refill_on,
  output plru_pkg::entry_idx_t refill_idx,
  output plru_pkg::entry_vec_t ref_num
);

  import plru_pkg::*;

  logic       all_vld;
  entry_idx_t free_idx;
  entry_idx_t tree_idx;
  entry_idx_t victim_idx;

  assign all_vld = &entry_vld;

  //------------------------------
  // Lowest invalid entry
  //------------------------------
  // Scan down so the lowest index is written last
  always_comb
  begin
    free_idx = '0;
    for (int i = PLRU_ENTRY_NUM - 1; i >= 0; i--)
    begin
      if (!entry_vld[i])
        free_idx = entry_idx_t'(i);
    end
  end

  //------------------------------
  // Tree walk
  //------------------------------
  // Each level adds one index bit, MSB first
  always_comb
  begin : tree_walk
    int node;
    node     = 0;
    tree_idx = '0;
    for (int l = 0; l < PLRU_IDX_W; l++)
    begin
      tree_idx[PLRU_IDX_W-1-l] = node_bits[node];
      // Step to child 1 on a set bit, else child 0
      node = 2 * node + 1 + int'(node_bits[node]);
    end
  end

  // The tree only matters once every entry is in use
  assign victim_idx = all_vld ? tree_idx : free_idx;

  //------------------------------
  // Refill index register
  //------------------------------
  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      refill_idx <= '0;
    else if (refill_on)
      refill_idx <= victim_idx;
  end

  // Entry number as seen by the uTLB
  assign ref_num = entry_vec_t'(1) << refill_idx;

endmodule

// ==== rtl/utlb_plru.sv ====
//------------------------------
// uTLB pseudo-LRU replacement top
// Hit tracker, node array, victim select
//------------------------------

`timescale 1ns/1ps

module utlb_plru (
  input  logic                 lru_clk,
  input  logic                 cpurst_b,
  input  plru_pkg::entry_vec_t entry_vld,
  input  plru_pkg::entry_vec_t hit_onehot0,
  input  plru_pkg::entry_vec_t hit_onehot1,
  input  logic                 hit_vld0,
  input  logic                 hit_vld1,
  input  logic                 refill_on,
  input  logic                 refill_vld,
  output plru_pkg::entry_vec_t ref_num
);

  import plru_pkg::*;

  port_updt_t [PLRU_HIT_PORTS-1:0] rd_updt;
  entry_idx_t                      refill_idx;
  tree_vec_t                       node_bits;

  plru_hit_track u_hit_track (
    .lru_clk     (lru_clk),
    .cpurst_b    (cpurst_b),
    .hit_onehot0 (hit_onehot0),
    .hit_onehot1 (hit_onehot1),
    .hit_vld0    (hit_vld0),
    .hit_vld1    (hit_vld1),
    .rd_updt     (rd_updt)
  );

  //------------------------------
  // Tree nodes in heap order
  //------------------------------
  // Level lvl holds 2**lvl nodes starting at bit 2**lvl - 1
  for (genvar lvl = 0; lvl < PLRU_IDX_W; lvl++)
  begin : g_level
    for (genvar pos = 0; pos < (1 << lvl); pos++)
    begin : g_node
      plru_node #(
        .LEVEL (lvl),
        .POS   (pos)
      ) u_node (
        .lru_clk    (lru_clk),
        .cpurst_b   (cpurst_b),
        .refill_vld (refill_vld),
        .refill_idx (refill_idx),
        .rd_updt    (rd_updt),
        .node_bit   (node_bits[(1 << lvl) - 1 + pos])
      );
    end
  end

  plru_victim_sel u_victim_sel (
    .lru_clk    (lru_clk),
    .cpurst_b   (cpurst_b),
    .entry_vld  (entry_vld),
    .node_bits  (node_bits),
    .refill_on  (refill_on),
    .refill_idx (refill_idx),
    .ref_num    (ref_num)
  );

endmodule

// ==== bench/plru_model.svh ====
//------------------------------
// Reference model of the tree PLRU
// Hit decode, path update, victim choice
//------------------------------

`ifndef PLRU_MODEL_SVH
`define PLRU_MODEL_SVH

// Only a true one-hot names an entry
function automatic entry_idx_t decode_hit(entry_vec_t vec);
  entry_idx_t idx;
  idx = '0;
  if ($countones(vec) == 1)
    idx = entry_idx_t'($clog2(vec));
  return idx;
endfunction

// Nodes on the path to idx, and values pointing away from it
function automatic void path_update(input entry_idx_t idx, output tree_vec_t mask,
                                    output tree_vec_t val);
  int node;
  mask = '0;
  val  = '0;
  for (int l = 0; l < PLRU_IDX_W; l++)
  begin
    // Level start in heap order plus the prefix of idx above this level
    node       = (1 << l) - 1 + int'(idx >> (PLRU_IDX_W - l));
    mask[node] = 1'b1;
    val[node]  = !idx[PLRU_IDX_W-1-l];
  end
endfunction

// Next tree after one clock edge
function automatic tree_vec_t step_tree(tree_vec_t tree, logic wr, entry_idx_t wr_idx,
                                        logic [1:0] rd, entry_idx_t idx0, entry_idx_t idx1);
  tree_vec_t wm;
  tree_vec_t wv;
  tree_vec_t m0;
  tree_vec_t v0;
  tree_vec_t m1;
  tree_vec_t v1;
  tree_vec_t nxt;
  logic      c0;
  logic      c1;
  path_update(wr_idx, wm, wv);
  path_update(idx0, m0, v0);
  path_update(idx1, m1, v1);
  nxt = tree;
  for (int n = 0; n < PLRU_NODE_NUM; n++)
  begin
    c0 = rd[0] && m0[n];
    c1 = rd[1] && m1[n];
    if (wr && wm[n])
      nxt[n] = wv[n];
    else if (c0 && !c1)
      nxt[n] = v0[n];
    else if (c1 && !c0)
      nxt[n] = v1[n];
    else if (c0 && c1 && (v0[n] == v1[n]))
      nxt[n] = v0[n];
  end
  return nxt;
endfunction

// Lowest free entry, else follow the node bits down
function automatic entry_idx_t pick_victim(tree_vec_t tree, entry_vec_t vld);
  entry_idx_t idx;
  int         node;
  int         i;
  idx = '0;
  if (&vld)
  begin
    for (int l = 0; l < PLRU_IDX_W; l++)
    begin
      node = (1 << l) - 1 + int'(idx);
      idx  = {idx[PLRU_IDX_W-2:0], tree[node]};
    end
  end
  else
  begin
    i = 0;
    while (vld[i])
      i++;
    idx = entry_idx_t'(i);
  end
  return idx;
endfunction

`endif

// ==== bench/tb_utlb_plru.sv ====
//------------------------------
// Testbench for utlb_plru
// Stimulus table, model expected values
// Check loop, watchdog and summary
//------------------------------

`timescale 1ns/1ps

module tb_utlb_plru;

  import plru_pkg::*;

  `include "plru_model.svh"

  localparam int RAND_ROWS = 64;

  typedef struct packed {
    logic [3:0] test;
    entry_vec_t vld;
    entry_vec_t hit0;
    entry_vec_t hit1;
    logic       hv0;
    logic       hv1;
    logic       ron;
    logic       rvld;
    entry_vec_t exp_ref;
  } row_t;

  logic       lru_clk;
  logic       cpurst_b;
  entry_vec_t entry_vld;
  entry_vec_t hit_onehot0;
  entry_vec_t hit_onehot1;
  logic       hit_vld0;
  logic       hit_vld1;
  logic       refill_on;
  logic       refill_vld;
  entry_vec_t ref_num;

  row_t       rows[$];
  row_t       idle;
  int         seed;
  int         errors;
  int         tests;
  int         test_rows;
  int         test_errs;
  logic       table_ready;

  utlb_plru DUT (
    .lru_clk     (lru_clk),
    .cpurst_b    (cpurst_b),
    .entry_vld   (entry_vld),
    .hit_onehot0 (hit_onehot0),
    .hit_onehot1 (hit_onehot1),
    .hit_vld0    (hit_vld0),
    .hit_vld1    (hit_vld1),
    .refill_on   (refill_on),
    .refill_vld  (refill_vld),
    .ref_num     (ref_num)
  );

  always #5 lru_clk = ~lru_clk;

  function automatic string test_name(logic [3:0] t);
    case (t)
      4'd1:    return "reset value";
      4'd2:    return "invalid first";
      4'd3:    return "refill walk";
      4'd4:    return "single port hit";
      4'd5:    return "two port hits";
      default: return "random mix";
    endcase
  endfunction

  task automatic add_row(int test, entry_vec_t vld, entry_vec_t hit0, logic hv0,
                         entry_vec_t hit1, logic hv1, logic ron, logic rvld);
    row_t row;
    row = '{4'(test), vld, hit0, hit1, hv0, hv1, ron, rvld, '0};
    rows.push_back(row);
  endtask

  //------------------------------
  // Stimulus table
  //------------------------------
  task automatic build_table();
    entry_vec_t  vld;
    entry_vec_t  h0;
    entry_vec_t  h1;
    logic [31:0] r;
    add_row(1, '0, '0, 0, '0, 0, 0, 0);
    add_row(1, '0, '0, 0, '0, 0, 0, 0);
    add_row(2, 16'hfff3, '0, 0, '0, 0, 1, 0);
    add_row(2, '1, '0, 0, '0, 0, 0, 0);
    add_row(2, 16'h7fff, '0, 0, '0, 0, 1, 0);
    add_row(2, 16'hfeff, '0, 0, '0, 0, 1, 0);
    // Capture a victim, then refill it
    for (int k = 0; k < 6; k++)
    begin
      add_row(3, '1, '0, 0, '0, 0, 1, 0);
      add_row(3, '1, '0, 0, '0, 0, 0, 1);
    end
    add_row(3, '1, '0, 0, '0, 0, 1, 0);
    add_row(4, '1, 16'h0020, 1, '0, 0, 0, 0);
    add_row(4, '1, '0, 0, '0, 0, 1, 0);
    // Port 1 flips the root back, the repeated port 0 hit must not undo it
    add_row(4, '1, '0, 0, 16'h0400, 1, 1, 0);
    add_row(4, '1, 16'h0020, 1, '0, 0, 1, 0);
    add_row(4, '1, '0, 0, '0, 0, 1, 0);
    add_row(5, '1, 16'h0002, 1, 16'h1000, 1, 0, 0);
    add_row(5, '1, '0, 0, '0, 0, 1, 0);
    // Halves swapped between ports, root still holds
    add_row(5, '1, 16'h2000, 1, 16'h0004, 1, 1, 0);
    add_row(5, '1, 16'h0080, 1, 16'h0080, 1, 1, 0);
    add_row(5, '1, '0, 0, '0, 0, 1, 0);
    add_row(5, '1, 16'h0008, 1, 16'h0200, 1, 0, 1);
    add_row(5, '1, '0, 0, '0, 0, 1, 0);
    for (int k = 0; k < RAND_ROWS; k++)
    begin
      r   = $random(seed);
      vld = (r[1:0] == 2'b00) ? entry_vec_t'($random(seed)) : '1;
      h0  = r[4] ? entry_vec_t'($random(seed)) : entry_vec_t'(1) << r[11:8];
      h1  = r[5] ? entry_vec_t'($random(seed)) : entry_vec_t'(1) << r[15:12];
      add_row(6, vld, h0, r[16], h1, r[17], r[18], r[19] & r[20]);
    end
  endtask

  // Run the model over the table to fill in ref_num after each row
  task automatic fill_expected();
    tree_vec_t  tree;
    entry_idx_t last0;
    entry_idx_t last1;
    entry_idx_t ref_idx;
    entry_idx_t h0;
    entry_idx_t h1;
    entry_idx_t victim;
    logic [1:0] rd;
    tree    = '0;
    last0   = '0;
    last1   = '0;
    ref_idx = '0;
    foreach (rows[i])
    begin
      h0     = decode_hit(rows[i].hit0);
      h1     = decode_hit(rows[i].hit1);
      rd[0]  = rows[i].hv0 && (h0 != last0);
      rd[1]  = rows[i].hv1 && (h1 != last1);
      victim = pick_victim(tree, rows[i].vld);
      tree   = step_tree(tree, rows[i].rvld, ref_idx, rd, h0, h1);
      if (rows[i].hv0)
        last0 = h0;
      if (rows[i].hv1)
        last1 = h1;
      if (rows[i].ron)
        ref_idx = victim;
      rows[i].exp_ref = entry_vec_t'(1) << ref_idx;
    end
  endtask

  task automatic drive_row(row_t row);
    entry_vld   <= row.vld;
    hit_onehot0 <= row.hit0;
    hit_onehot1 <= row.hit1;
    hit_vld0    <= row.hv0;
    hit_vld1    <= row.hv1;
    refill_on   <= row.ron;
    refill_vld  <= row.rvld;
  endtask

  task automatic check_row(int i);
    test_rows++;
    if (ref_num !== rows[i].exp_ref)
    begin
      $display("[ERROR] %0t ns: row %0d ref_num %h, expected %h",
               $time, i, ref_num, rows[i].exp_ref);
      errors++;
      test_errs++;
    end
    // Last row of a test closes its report line
    if ((i == rows.size() - 1) || (rows[i+1].test != rows[i].test))
    begin
      $display("test %0d %s: %0d rows, %0d errors",
               rows[i].test, test_name(rows[i].test), test_rows, test_errs);
      tests++;
      test_rows = 0;
      test_errs = 0;
    end
  endtask

  //------------------------------
  // Main sequence
  //------------------------------
  initial
  begin
    lru_clk     = 1'b0;
    cpurst_b    = 1'b0;
    entry_vld   = '0;
    hit_onehot0 = '0;
    hit_onehot1 = '0;
    hit_vld0    = 1'b0;
    hit_vld1    = 1'b0;
    refill_on   = 1'b0;
    refill_vld  = 1'b0;
    seed        = 32'hab2b6918;
    errors      = 0;
    tests       = 0;
    test_rows   = 0;
    test_errs   = 0;
    table_ready = 1'b0;
    idle        = '0;
    idle.vld    = '1;
    build_table();
    fill_expected();
    table_ready = 1'b1;
    repeat (3) @(posedge lru_clk);
    cpurst_b <= 1'b1;
    // Row i is sampled one edge after it is driven, checked at the next low phase
    for (int i = 0; i <= rows.size(); i++)
    begin
      @(posedge lru_clk);
      if (i < rows.size())
        drive_row(rows[i]);
      else
        drive_row(idle);
      @(negedge lru_clk);
      if (i > 0)
        check_row(i - 1);
    end
    $display("%0d tests, %0d rows checked, %0d errors", tests, rows.size(), errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Reset, one cycle per row and a margin
  initial
  begin
    wait (table_ready);
    #((rows.size() + 20) * 10);
    $display("Timeout: the run did not reach the end of the table in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+bench
rtl/plru_pkg.sv
rtl/plru_hit_track.sv
rtl/plru_node.sv
rtl/plru_victim_sel.sv
rtl/utlb_plru.sv
bench/tb_utlb_plru.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the uTLB PLRU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f tb.f --top-module tb_utlb_plru \
  -Mdir obj_dir -o sim_utlb_plru

./obj_dir/sim_utlb_plru | tee sim.log

if grep -q "PASS: all tests" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
